//--- filelist.f
+incdir+sim
src/pmu_pkg.sv
src/pmu_cfg_if.sv
src/pmu_event_select.sv
src/pmu_counters.sv
src/pmu_intr_unit.sv
src/pmu_top.sv
sim/tb_pmu_top.sv

//--- Bender.yml
package:
  name: pmu

sources:
  - src/pmu_pkg.sv
  - src/pmu_cfg_if.sv
  - src/pmu_event_select.sv
  - src/pmu_counters.sv
  - src/pmu_intr_unit.sv
  - src/pmu_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_pmu_top.sv

//--- sim/pmu_model.svh
`ifndef PMU_MODEL_SVH
`define PMU_MODEL_SVH

// ----------------------------------------
// Reference model state
// ----------------------------------------

logic [REG_WIDTH-1:0]  cnt_m [N_COUNTERS];
// Copy of the select register in front of the counters
logic [N_COUNTERS-1:0] sel_m;
logic [N_COUNTERS-1:0] wrap_m;
logic [N_COUNTERS-1:0] ovf_m;
logic                  quota_m;

// Idle state after reset
task automatic clear_state();
    for (int c = 0; c < N_COUNTERS; c++) begin
        cnt_m[c] = '0;
    end
    sel_m   = '0;
    wrap_m  = '0;
    ovf_m   = '0;
    quota_m = 1'b0;
endtask

// Event bit each counter takes at this edge, self-test applied
function automatic logic [N_COUNTERS-1:0] pick_events();
    logic [N_CROSSBAR_REGS*REG_WIDTH-1:0] flat;
    logic [N_COUNTERS-1:0]                pick;
    logic [1:0]                           mode;
    int                                   idx;
    for (int w = 0; w < N_CROSSBAR_REGS; w++) begin
        flat[w*REG_WIDTH +: REG_WIDTH] = regs_i[BASE_CROSSBAR + w];
    end
    // Select fields run on from one word into the next
    for (int c = 0; c < N_COUNTERS; c++) begin
        idx     = int'(flat[c*SEL_BITS +: SEL_BITS]);
        pick[c] = (idx < N_SOC_EV) ? events_i[idx] : 1'b0;
    end
    mode = regs_i[BASE_CFG][CFG_SELFTEST_LSB +: 2];
    if (mode == SELFTEST_ALL_ON) begin
        pick = '1;
    end else if (mode == SELFTEST_ALL_OFF) begin
        pick = '0;
    end else if (mode == SELFTEST_ONE_ON) begin
        pick = N_COUNTERS'(1);
    end
    return pick;
endfunction

// One rising edge, every stage reads the state from before it
task automatic advance_edge();
    logic [REG_WIDTH-1:0] cfg;
    logic [REG_WIDTH+7:0] sum;
    cfg = regs_i[BASE_CFG];
    sum = '0;
    for (int c = 0; c < N_COUNTERS; c++) begin
        if (regs_i[BASE_QUOTA_MASK][c]) begin
            sum = sum + cnt_m[c];
        end
    end
    // Result stage
    quota_m = cfg[CFG_QUOTA_SOFTRST_BIT] ? 1'b0 : (sum > regs_i[BASE_QUOTA_LIMIT]);
    if (cfg[CFG_OVF_SOFTRST_BIT]) begin
        ovf_m = '0;
    end else if (cfg[CFG_OVF_EN_BIT]) begin
        ovf_m = ovf_m | wrap_m;
    end
    // Execute stage, soft reset over load over count
    for (int c = 0; c < N_COUNTERS; c++) begin
        wrap_m[c] = 1'b0;
        if (cfg[CFG_SOFTRST_BIT]) begin
            cnt_m[c] = '0;
        end else if (wrapper_we_i) begin
            cnt_m[c] = regs_i[BASE_COUNTERS + c];
        end else if (cfg[CFG_EN_BIT]) begin
            wrap_m[c] = sel_m[c] & (&cnt_m[c]);
            cnt_m[c]  = cnt_m[c] + REG_WIDTH'(sel_m[c]);
        end
    end
    // Decode stage
    sel_m = pick_events();
endtask

`endif

//--- sim/tb_pmu_top.sv
`timescale 1ns/1ps

module tb_pmu_top
    import pmu_pkg::*;
();

    localparam int REG_WIDTH        = 32;
    localparam int N_COUNTERS       = 9;
    localparam int N_SOC_EV         = 32;
    // Register map recomputed with the DUT packing rule
    localparam int SEL_BITS         = $clog2(N_SOC_EV);
    localparam int BASE_OVF_MASK    = BASE_COUNTERS + N_COUNTERS;
    localparam int BASE_OVF_VECT    = BASE_OVF_MASK + 1;
    localparam int BASE_QUOTA_MASK  = BASE_OVF_VECT + 1;
    localparam int BASE_QUOTA_LIMIT = BASE_QUOTA_MASK + 1;
    localparam int BASE_CROSSBAR    = BASE_QUOTA_LIMIT + 1;
    localparam int N_CROSSBAR_REGS  = (N_COUNTERS * SEL_BITS + REG_WIDTH - 1) / REG_WIDTH;
    localparam int TOTAL_NREGS      = BASE_CROSSBAR + N_CROSSBAR_REGS;

    // Test lengths in cycles
    localparam int LEN_XBAR     = 200;
    localparam int LEN_SELFTEST = 30;
    localparam int LEN_QUOTA    = 150;
    localparam int TIMEOUT_CYCLES = 6 + LEN_XBAR + 4 * LEN_SELFTEST + 32 + 26
                                  + LEN_QUOTA + 1 + 100;

    logic                 clk_i;
    logic                 rstn_i;
    logic [REG_WIDTH-1:0] regs_i [TOTAL_NREGS];
    logic [REG_WIDTH-1:0] regs_o [TOTAL_NREGS];
    logic                 wrapper_we_i;
    logic [N_SOC_EV-1:0]  events_i;
    logic                 intr_overflow_o;
    logic                 intr_quota_o;

    integer seed = 32'h4ebd_343a;
    int     test_errs;
    int     tests_passed;
    int     tests_failed;
    int     cycle_count;

    `include "pmu_model.svh"

    pmu_top #(
        .REG_WIDTH  (REG_WIDTH),
        .N_COUNTERS (N_COUNTERS),
        .N_SOC_EV   (N_SOC_EV)
    ) UUT (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .regs_i          (regs_i),
        .regs_o          (regs_o),
        .wrapper_we_i    (wrapper_we_i),
        .events_i        (events_i),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

    // ----------------------------------------
    // Clock and run limit
    // ----------------------------------------

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [REG_WIDTH-1:0] cfg_word(
        input logic       en,
        input logic       softrst,
        input logic       ovf_en,
        input logic       ovf_softrst,
        input logic       quota_softrst,
        input logic [1:0] mode
    );
        logic [REG_WIDTH-1:0] word;
        word                            = '0;
        word[CFG_EN_BIT]                = en;
        word[CFG_SOFTRST_BIT]           = softrst;
        word[CFG_OVF_EN_BIT]            = ovf_en;
        word[CFG_OVF_SOFTRST_BIT]       = ovf_softrst;
        word[CFG_QUOTA_SOFTRST_BIT]     = quota_softrst;
        word[CFG_SELFTEST_LSB +: 2]     = mode;
        return word;
    endfunction

    task automatic expect_value(input string name, input logic [REG_WIDTH-1:0] exp,
                                input logic [REG_WIDTH-1:0] act);
        assert (act === exp) else begin
            $display("ERR %0t %s expected 0x%h actual 0x%h", $time, name, exp, act);
            test_errs++;
        end
    endtask

    // Counters, vector and both interrupt lines against the model
    task automatic check_outputs();
        for (int c = 0; c < N_COUNTERS; c++) begin
            expect_value($sformatf("regs_o[%0d]", BASE_COUNTERS + c), cnt_m[c],
                         regs_o[BASE_COUNTERS + c]);
        end
        expect_value("regs_o[ovf_vect]", REG_WIDTH'(ovf_m), regs_o[BASE_OVF_VECT]);
        expect_value("intr_overflow_o", |(ovf_m & regs_i[BASE_OVF_MASK][N_COUNTERS-1:0]),
                     intr_overflow_o);
        expect_value("intr_quota_o", quota_m, intr_quota_o);
    endtask

    // Model follows the edge, outputs are compared half a cycle later
    task automatic step_cycle();
        @(posedge clk_i);
        advance_edge();
        @(negedge clk_i);
        check_outputs();
    endtask

    task automatic close_test(input string name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin
        logic [1:0] modes [4];
        modes[0] = SELFTEST_ALL_ON;
        modes[1] = SELFTEST_ALL_OFF;
        modes[2] = SELFTEST_ONE_ON;
        modes[3] = SELFTEST_NONE;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count  = 0;
        rstn_i       = 1'b0;
        wrapper_we_i = 1'b0;
        events_i     = '0;
        for (int r = 0; r < TOTAL_NREGS; r++) begin
            regs_i[r] = $random(seed);
        end
        regs_i[BASE_CFG] = cfg_word(0, 0, 0, 0, 0, SELFTEST_NONE);
        clear_state();
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        // Reset state and software words echoed
        check_outputs();
        expect_value("regs_o[cfg]", regs_i[BASE_CFG], regs_o[BASE_CFG]);
        expect_value("regs_o[ovf_mask]", regs_i[BASE_OVF_MASK], regs_o[BASE_OVF_MASK]);
        expect_value("regs_o[quota_mask]", regs_i[BASE_QUOTA_MASK], regs_o[BASE_QUOTA_MASK]);
        expect_value("regs_o[quota_limit]", regs_i[BASE_QUOTA_LIMIT],
                     regs_o[BASE_QUOTA_LIMIT]);
        for (int w = 0; w < N_CROSSBAR_REGS; w++) begin
            expect_value("regs_o[crossbar]", regs_i[BASE_CROSSBAR + w],
                         regs_o[BASE_CROSSBAR + w]);
        end
        close_test("reset");

        // Crossbar counting with enable off for the last 10 of every 50
        for (int w = 0; w < N_CROSSBAR_REGS; w++) begin
            regs_i[BASE_CROSSBAR + w] = $random(seed);
        end
        for (int i = 0; i < LEN_XBAR; i++) begin
            regs_i[BASE_CFG] = cfg_word((i % 50) < 40, 0, 0, 0, 0, SELFTEST_NONE);
            events_i         = $random(seed);
            step_cycle();
        end
        close_test("crossbar counting");

        for (int m = 0; m < 4; m++) begin
            regs_i[BASE_CFG] = cfg_word(1, 0, 0, 0, 0, modes[m]);
            for (int i = 0; i < LEN_SELFTEST; i++) begin
                events_i = $random(seed);
                step_cycle();
            end
        end
        close_test("self-test modes");

        // Load, then let it count a little
        for (int k = 0; k < 10; k++) begin
            for (int c = 0; c < N_COUNTERS; c++) begin
                regs_i[BASE_COUNTERS + c] = $random(seed);
            end
            wrapper_we_i = 1'b1;
            events_i     = $random(seed);
            step_cycle();
            wrapper_we_i = 1'b0;
            step_cycle();
            step_cycle();
        end
        // Soft reset against a load
        regs_i[BASE_CFG] = cfg_word(1, 1, 0, 0, 0, SELFTEST_NONE);
        wrapper_we_i     = 1'b1;
        step_cycle();
        regs_i[BASE_CFG] = cfg_word(1, 0, 0, 0, 0, SELFTEST_NONE);
        wrapper_we_i     = 1'b0;
        step_cycle();
        close_test("load and soft reset");

        // First pass wraps with overflow off, second with it on
        regs_i[BASE_OVF_MASK] = $random(seed);
        for (int p = 0; p < 2; p++) begin
            for (int c = 0; c < N_COUNTERS; c++) begin
                regs_i[BASE_COUNTERS + c] = {REG_WIDTH{1'b1}} - ($random(seed) & 32'h3);
            end
            regs_i[BASE_CFG] = cfg_word(1, 0, p == 1, 0, 0,
                                        (p == 1) ? SELFTEST_NONE : SELFTEST_ALL_ON);
            wrapper_we_i = 1'b1;
            step_cycle();
            wrapper_we_i = 1'b0;
            for (int i = 0; i < 8; i++) begin
                events_i = $random(seed);
                step_cycle();
            end
        end
        // Vector holds with no events
        regs_i[BASE_CFG] = cfg_word(1, 0, 1, 0, 0, SELFTEST_ALL_OFF);
        repeat (5) step_cycle();
        regs_i[BASE_CFG] = cfg_word(1, 0, 1, 1, 0, SELFTEST_ALL_OFF);
        step_cycle();
        regs_i[BASE_CFG] = cfg_word(1, 0, 1, 0, 0, SELFTEST_ALL_OFF);
        repeat (2) step_cycle();
        close_test("overflow");

        // Quota from a cleared bank
        regs_i[BASE_CFG] = cfg_word(1, 1, 0, 0, 0, SELFTEST_NONE);
        step_cycle();
        for (int i = 0; i < LEN_QUOTA; i++) begin
            if (i % 30 == 0) begin
                regs_i[BASE_QUOTA_MASK]  = $random(seed);
                regs_i[BASE_QUOTA_LIMIT] = $random(seed) & 32'h1ff;
            end
            regs_i[BASE_CFG] = cfg_word(1, 0, 0, 0, (i >= 100) && (i < 120), SELFTEST_NONE);
            events_i         = $random(seed);
            step_cycle();
            if ((i >= 100) && (i < 120)) begin
                // Held soft reset keeps the line low whatever the sum
                expect_value("intr_quota_o", '0, intr_quota_o);
            end
        end
        close_test("quota");

        $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- src/pmu_top.sv
`timescale 1ns/1ps

module pmu_top
    import pmu_pkg::*;
#(
    parameter int REG_WIDTH  = 32,
    parameter int N_COUNTERS = 9,
    parameter int N_SOC_EV   = 32,
    // Crossbar select width
    localparam int SEL_BITS         = $clog2(N_SOC_EV),
    // One word each, right after the counters
    localparam int BASE_OVF_MASK    = BASE_COUNTERS + N_COUNTERS,
    localparam int BASE_OVF_VECT    = BASE_OVF_MASK + 1,
    localparam int BASE_QUOTA_MASK  = BASE_OVF_VECT + 1,
    localparam int BASE_QUOTA_LIMIT = BASE_QUOTA_MASK + 1,
    localparam int BASE_CROSSBAR    = BASE_QUOTA_LIMIT + 1,
    // Packed select fields, rounded up to whole words
    localparam int N_CROSSBAR_REGS  = (N_COUNTERS * SEL_BITS + REG_WIDTH - 1) / REG_WIDTH,
    localparam int TOTAL_NREGS      = BASE_CROSSBAR + N_CROSSBAR_REGS
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    // Flat register file owned by the bus wrapper
    input  logic [REG_WIDTH-1:0] regs_i [TOTAL_NREGS],
    output logic [REG_WIDTH-1:0] regs_o [TOTAL_NREGS],
    input  logic                 wrapper_we_i,
    input  logic [N_SOC_EV-1:0]  events_i,
    output logic                 intr_overflow_o,
    output logic                 intr_quota_o
);

    // Masks and the overflow vector must fit one word
    if (N_COUNTERS > REG_WIDTH) begin : g_size_chk
        $error("pmu_top: N_COUNTERS exceeds REG_WIDTH");
    end

    // ----------------------------------------
    // Register map, inbound
    // ----------------------------------------

    logic [REG_WIDTH-1:0]  mask_words [3];
    logic [REG_WIDTH-1:0]  xbar_words [N_CROSSBAR_REGS];
    logic [REG_WIDTH-1:0]  load_words [N_COUNTERS];
    logic [REG_WIDTH-1:0]  counter_values [N_COUNTERS];
    logic [N_COUNTERS-1:0] sel_events;
    logic [N_COUNTERS-1:0] wrap;
    logic [N_COUNTERS-1:0] ovf_vect;

    // Same order as the select port expects
    assign mask_words[0] = regs_i[BASE_OVF_MASK];
    assign mask_words[1] = regs_i[BASE_QUOTA_MASK];
    assign mask_words[2] = regs_i[BASE_QUOTA_LIMIT];

    for (genvar w = 0; w < N_CROSSBAR_REGS; w++) begin : g_xbar_in
        assign xbar_words[w] = regs_i[BASE_CROSSBAR + w];
    end

    for (genvar c = 0; c < N_COUNTERS; c++) begin : g_cnt_map
        assign load_words[c]            = regs_i[BASE_COUNTERS + c];
        assign regs_o[BASE_COUNTERS + c] = counter_values[c];
    end

    // ----------------------------------------
    // Register map, outbound
    // ----------------------------------------

    // Software-owned words read back unchanged
    assign regs_o[BASE_CFG]         = regs_i[BASE_CFG];
    assign regs_o[BASE_OVF_MASK]    = regs_i[BASE_OVF_MASK];
    assign regs_o[BASE_QUOTA_MASK]  = regs_i[BASE_QUOTA_MASK];
    assign regs_o[BASE_QUOTA_LIMIT] = regs_i[BASE_QUOTA_LIMIT];

    for (genvar w = 0; w < N_CROSSBAR_REGS; w++) begin : g_xbar_out
        assign regs_o[BASE_CROSSBAR + w] = regs_i[BASE_CROSSBAR + w];
    end

    // Upper bits read as zero
    assign regs_o[BASE_OVF_VECT] = REG_WIDTH'(ovf_vect);

    // ----------------------------------------
    // Pipeline: decode, execute, result
    // ----------------------------------------

    pmu_cfg_if #(
        .REG_WIDTH  (REG_WIDTH),
        .N_COUNTERS (N_COUNTERS)
    ) cfg_bus ();

    pmu_event_select #(
        .REG_WIDTH  (REG_WIDTH),
        .N_COUNTERS (N_COUNTERS),
        .N_SOC_EV   (N_SOC_EV)
    ) u_select (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .cfg_word_i      (regs_i[BASE_CFG]),
        .mask_regs_i     (mask_words),
        .crossbar_regs_i (xbar_words),
        .events_i        (events_i),
        .cfg             (cfg_bus.decode),
        .sel_events_o    (sel_events)
    );

    pmu_counters #(
        .REG_WIDTH  (REG_WIDTH),
        .N_COUNTERS (N_COUNTERS)
    ) u_counters (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .cfg      (cfg_bus.execute),
        .we_i     (wrapper_we_i),
        .load_i   (load_words),
        .events_i (sel_events),
        .count_o  (counter_values),
        .wrap_o   (wrap)
    );

    pmu_intr_unit #(
        .REG_WIDTH  (REG_WIDTH),
        .N_COUNTERS (N_COUNTERS)
    ) u_intr (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .cfg             (cfg_bus.result),
        .count_i         (counter_values),
        .wrap_i          (wrap),
        .ovf_vect_o      (ovf_vect),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

endmodule

//--- src/pmu_intr_unit.sv
`timescale 1ns/1ps

module pmu_intr_unit #(
    parameter int REG_WIDTH  = 32,
    parameter int N_COUNTERS = 9
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    pmu_cfg_if.result             cfg,
    input  logic [REG_WIDTH-1:0]  count_i [N_COUNTERS],
    // One-cycle wrap pulses from the counter bank
    input  logic [N_COUNTERS-1:0] wrap_i,
    output logic [N_COUNTERS-1:0] ovf_vect_o,
    output logic                  intr_overflow_o,
    output logic                  intr_quota_o
);

    // Sum width, room for N_COUNTERS full words
    localparam int SUM_W = REG_WIDTH + $clog2(N_COUNTERS);

    // ----------------------------------------
    // Overflow
    // ----------------------------------------

    // Sticky until cleared by software
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ovf_vect_o <= '0;
        end else if (cfg.ovf_softrst) begin
            ovf_vect_o <= '0;
        end else if (cfg.ovf_en) begin
            ovf_vect_o <= ovf_vect_o | wrap_i;
        end
    end

    // Only unmasked counters raise the line
    assign intr_overflow_o = |(ovf_vect_o & cfg.ovf_mask);

    // ----------------------------------------
    // Quota
    // ----------------------------------------

    logic [SUM_W-1:0] quota_sum;
    logic             quota_hit;

    // Single-cycle adder tree over the selected counters
    always_comb begin
        quota_sum = '0;
        for (int c = 0; c < N_COUNTERS; c++) begin
            if (cfg.quota_mask[c]) begin
                quota_sum = quota_sum + SUM_W'(count_i[c]);
            end
        end
    end

    // Strictly above the limit
    assign quota_hit = quota_sum > SUM_W'(cfg.quota_limit);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            intr_quota_o <= 1'b0;
        end else if (cfg.quota_softrst) begin
            // Held low while software clears it
            intr_quota_o <= 1'b0;
        end else begin
            intr_quota_o <= quota_hit;
        end
    end

    // A new overflow interrupt traces back to an enabled wrap on an unmasked counter
    a_ovf_cause: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(intr_overflow_o) && $stable(cfg.ovf_mask)
        |-> $past(cfg.ovf_en && |(wrap_i & cfg.ovf_mask)));

endmodule

//--- src/pmu_counters.sv
`timescale 1ns/1ps

module pmu_counters #(
    parameter int REG_WIDTH  = 32,
    parameter int N_COUNTERS = 9
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    pmu_cfg_if.execute            cfg,
    // Wrapper write level, loads every counter
    input  logic                  we_i,
    input  logic [REG_WIDTH-1:0]  load_i [N_COUNTERS],
    // Selected events, one bit per counter
    input  logic [N_COUNTERS-1:0] events_i,
    output logic [REG_WIDTH-1:0]  count_o [N_COUNTERS],
    output logic [N_COUNTERS-1:0] wrap_o
);

    // ----------------------------------------
    // Counter bank
    // ----------------------------------------

    for (genvar c = 0; c < N_COUNTERS; c++) begin : g_cnt

        logic at_max;

        // Next increment rolls over to zero
        assign at_max = &count_o[c];

        // Priority: soft reset, then load, then count
        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                count_o[c] <= '0;
                wrap_o[c]  <= 1'b0;
            end else if (cfg.softrst) begin
                count_o[c] <= '0;
                wrap_o[c]  <= 1'b0;
            end else if (we_i) begin
                count_o[c] <= load_i[c];
                wrap_o[c]  <= 1'b0;
            end else if (cfg.en) begin
                count_o[c] <= count_o[c] + REG_WIDTH'(events_i[c]);
                // Pulse rises together with the zero value
                wrap_o[c]  <= events_i[c] & at_max;
            end else begin
                // Held value, no wrap possible
                wrap_o[c]  <= 1'b0;
            end
        end

        // Soft reset empties the bank and kills any pending wrap
        a_softrst: assert property (@(posedge clk_i) disable iff (!rstn_i)
            cfg.softrst |=> (count_o[c] == '0) && !wrap_o[c]);

    end

endmodule

//--- src/pmu_event_select.sv
`timescale 1ns/1ps

module pmu_event_select
    import pmu_pkg::*;
#(
    parameter int REG_WIDTH  = 32,
    parameter int N_COUNTERS = 9,
    parameter int N_SOC_EV   = 32,
    // Select field width and crossbar word count
    localparam int SEL_W       = $clog2(N_SOC_EV),
    localparam int N_XBAR_REGS = (N_COUNTERS * SEL_W + REG_WIDTH - 1) / REG_WIDTH
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic [REG_WIDTH-1:0]  cfg_word_i,
    // 0 overflow mask, 1 quota mask, 2 quota limit
    input  logic [REG_WIDTH-1:0]  mask_regs_i [3],
    input  logic [REG_WIDTH-1:0]  crossbar_regs_i [N_XBAR_REGS],
    input  logic [N_SOC_EV-1:0]   events_i,
    pmu_cfg_if.decode             cfg,
    output logic [N_COUNTERS-1:0] sel_events_o
);

    // ----------------------------------------
    // Configuration decode
    // ----------------------------------------

    logic [1:0] selftest;

    assign cfg.en            = cfg_word_i[CFG_EN_BIT];
    assign cfg.softrst       = cfg_word_i[CFG_SOFTRST_BIT];
    assign cfg.ovf_en        = cfg_word_i[CFG_OVF_EN_BIT];
    assign cfg.ovf_softrst   = cfg_word_i[CFG_OVF_SOFTRST_BIT];
    assign cfg.quota_softrst = cfg_word_i[CFG_QUOTA_SOFTRST_BIT];
    assign selftest          = cfg_word_i[CFG_SELFTEST_LSB +: 2];

    // Masks only use the low N_COUNTERS bits
    assign cfg.ovf_mask    = mask_regs_i[0][N_COUNTERS-1:0];
    assign cfg.quota_mask  = mask_regs_i[1][N_COUNTERS-1:0];
    assign cfg.quota_limit = mask_regs_i[2];

    // ----------------------------------------
    // Crossbar
    // ----------------------------------------

    logic [N_XBAR_REGS*REG_WIDTH-1:0] xbar_flat;
    logic [SEL_W-1:0]                 xbar_field [N_COUNTERS];
    logic [N_COUNTERS-1:0]            xbar_hit;
    logic [N_COUNTERS-1:0]            sel_next;

    // Fields are packed from bit 0 and may straddle words
    always_comb begin
        for (int w = 0; w < N_XBAR_REGS; w++) begin
            xbar_flat[w*REG_WIDTH +: REG_WIDTH] = crossbar_regs_i[w];
        end
    end

    for (genvar c = 0; c < N_COUNTERS; c++) begin : g_xbar
        assign xbar_field[c] = xbar_flat[c*SEL_W +: SEL_W];
        // Codes past the last event read as idle
        assign xbar_hit[c] = (int'(xbar_field[c]) < N_SOC_EV) ? events_i[xbar_field[c]] : 1'b0;
    end

    // Self-test override
    always_comb begin
        case (selftest)
            SELFTEST_ALL_ON:  sel_next = '1;
            SELFTEST_ALL_OFF: sel_next = '0;
            SELFTEST_ONE_ON: begin
                sel_next    = '0;
                sel_next[0] = 1'b1;
            end
            default:          sel_next = xbar_hit;
        endcase
    end

    // One register stage before the counters
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sel_events_o <= '0;
        end else begin
            sel_events_o <= sel_next;
        end
    end

    // All-off mode silences the counters one cycle on
    a_all_off: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (selftest == SELFTEST_ALL_OFF) |=> (sel_events_o == '0));

endmodule

//--- src/pmu_cfg_if.sv
`timescale 1ns/1ps

// Decoded configuration, fanned out from the decode stage
interface pmu_cfg_if #(
    parameter int REG_WIDTH  = 32,
    parameter int N_COUNTERS = 9
);

    // Counter bank controls
    logic                  en;
    logic                  softrst;

    // Overflow controls
    logic                  ovf_en;
    logic                  ovf_softrst;
    logic [N_COUNTERS-1:0] ovf_mask;

    // Quota controls
    logic                  quota_softrst;
    logic [N_COUNTERS-1:0] quota_mask;
    logic [REG_WIDTH-1:0]  quota_limit;

    // Decode stage drives everything
    modport decode (
        output en, softrst,
        output ovf_en, ovf_softrst, ovf_mask,
        output quota_softrst, quota_mask, quota_limit
    );

    // Counter bank needs only enable and clear
    modport execute (
        input en, softrst
    );

    // Interrupt unit takes the overflow and quota controls
    modport result (
        input ovf_en, ovf_softrst, ovf_mask,
        input quota_softrst, quota_mask, quota_limit
    );

endinterface

//--- src/pmu_pkg.sv
package pmu_pkg;

    // ----------------------------------------
    // Register map
    // ----------------------------------------

    // Main configuration word
    localparam int BASE_CFG = 0;
    // First counter word, counters follow back to back
    localparam int BASE_COUNTERS = 1;

    // ----------------------------------------
    // Configuration word bit positions
    // ----------------------------------------

    // Counter bank enable
    localparam int CFG_EN_BIT = 0;
    // Clears every counter
    localparam int CFG_SOFTRST_BIT = 1;
    // Lets wraps set the overflow vector
    localparam int CFG_OVF_EN_BIT = 2;
    // Clears the sticky overflow vector
    localparam int CFG_OVF_SOFTRST_BIT = 3;
    // Holds the quota interrupt low
    localparam int CFG_QUOTA_SOFTRST_BIT = 4;
    // Self-test field, bits 31:30
    localparam int CFG_SELFTEST_LSB = 30;

    // ----------------------------------------
    // Self-test codes
    // ----------------------------------------

    // Normal operation, events come through the crossbar
    localparam logic [1:0] SELFTEST_NONE = 2'b00;
    // Every counter sees an event each cycle
    localparam logic [1:0] SELFTEST_ALL_ON = 2'b01;
    // No counter sees an event
    localparam logic [1:0] SELFTEST_ALL_OFF = 2'b10;
    // Counter 0 only
    localparam logic [1:0] SELFTEST_ONE_ON = 2'b11;

endpackage
